// ==== Bender.yml ====
package:
  name: retire_unit

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/retire_pkg.sv
      - hw/axi_lite_pkg.sv
      - hw/rob_pointer.sv
      - hw/retire.sv
      - hw/retire_csr.sv
      - hw/retire_unit_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/retire_tb.sv

// ==== all.f ====
+incdir+hw
hw/retire_pkg.sv
hw/axi_lite_pkg.sv
hw/rob_pointer.sv
hw/retire.sv
hw/retire_csr.sv
hw/retire_unit_top.sv
bench/retire_tb.sv

// ==== bench/retire_tb.sv ====
`timescale 1ns/1ps

`include "retire_config.svh"

module retire_tb import retire_pkg::*, axi_lite_pkg::*; ();

    localparam int rob_sz     = `RETIRE_ROB_SZ;
    localparam int clk_period = 8;

    // cycle budgets per test
    localparam int budget_in_order     = 60;
    localparam int budget_out_of_order = 60;
    localparam int budget_exceptions   = 80;
    localparam int budget_backpressure = 100;
    localparam int budget_flush        = 120;
    localparam int budget_counter      = 100;
    localparam int watchdog_cycles     = 2 * (budget_in_order + budget_out_of_order
                                       + budget_exceptions + budget_backpressure
                                       + budget_flush + budget_counter);

    logic          clock;
    logic          rst_n;
    logic          alloc_valid;
    logic          alloc_ready;
    rob_idx_t      alloc_index;
    co_re_packet_t co_packet;
    logic [3:0]    mem2proc_response;
    logic          mispredict_flush;
    commit_t       commit;
    axil_req_t     s_axil_req;
    axil_resp_t    s_axil_resp;

    logic [15:0]   lfsr_state = 16'd17152;
    commit_t       got_q[$];
    commit_t       exp_q[$];
    co_re_packet_t pk [rob_sz];
    logic [3:0]    rsp [rob_sz];
    int            order [rob_sz];
    // expected pointer positions
    int            tb_head;
    int            tb_tail;
    // commits the tests have asked for so far
    int            commits_expected;
    int            check_errors;
    int            test_errors;
    int            tests_passed;
    int            tests_failed;

    retire_unit_top uut (
        .clock             (clock),
        .rst_n             (rst_n),
        .alloc_valid       (alloc_valid),
        .alloc_ready       (alloc_ready),
        .alloc_index       (alloc_index),
        .co_packet         (co_packet),
        .mem2proc_response (mem2proc_response),
        .mispredict_flush  (mispredict_flush),
        .commit            (commit),
        .s_axil_req        (s_axil_req),
        .s_axil_resp       (s_axil_resp)
    );

    initial clock = 1'b0;
    always #(clk_period / 2) clock = ~clock;

    // monitor samples the registered commit port on each edge
    always @(posedge clock) begin
        if (rst_n && commit.valid) begin
            got_q.push_back(commit);
        end
    end

    // 16 bit fibonacci lfsr with taps 16 14 13 11
    // one step per bit taken
    function automatic logic [31:0] lfsr_bits(int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // random payload, no exception flags
    function automatic co_re_packet_t new_packet(int idx);
        co_re_packet_t p;
        p = '0;
        p.valid        = 1'b1;
        p.rob_index    = rob_idx_t'(idx % rob_sz);
        p.npc          = lfsr_bits(32);
        p.regfile_en   = 1'(lfsr_bits(1));
        p.regfile_idx  = 5'(lfsr_bits(5));
        p.regfile_data = lfsr_bits(32);
        return p;
    endfunction

    // record that the packet must produce
    function automatic commit_t expected_commit(co_re_packet_t p, exception_code_e code);
        commit_t c;
        c.valid        = 1'b1;
        c.error_status = code;
        c.wr_en        = p.regfile_en;
        c.wr_idx       = p.regfile_idx;
        c.wr_data      = p.regfile_data;
        c.npc          = p.npc;
        return c;
    endfunction

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            check_errors++;
            test_errors++;
        end
    endtask

    task automatic report_error(string msg);
        $display("ERROR %0t %s", $time, msg);
        check_errors++;
        test_errors++;
    endtask

    // one summary line per test
    task automatic end_test(string name);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %s ok", name);
        end else begin
            tests_failed++;
            $display("test %s %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    // clean packets for consecutive slots in program order
    task automatic fill_packets(int first, int n);
        for (int k = 0; k < n; k++) begin
            pk[k]    = new_packet(first + k);
            rsp[k]   = 4'(lfsr_bits(4));
            order[k] = k;
            exp_q.push_back(expected_commit(pk[k], no_error));
        end
    endtask

    // one dispatch per cycle
    task automatic alloc_slots(int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clock);
            alloc_valid <= 1'b1;
            @(negedge clock);
            compare_value("alloc_ready", alloc_ready, 1'b1);
            compare_value("alloc_index", alloc_index, tb_tail % rob_sz);
            tb_tail++;
        end
        @(posedge clock);
        alloc_valid <= 1'b0;
    endtask

    // one completion per cycle in the order array
    task automatic send_completions(int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clock);
            co_packet         <= pk[order[k]];
            mem2proc_response <= rsp[order[k]];
        end
        @(posedge clock);
        co_packet         <= '0;
        mem2proc_response <= 4'h0;
    endtask

    task automatic compare_commits(int budget);
        commit_t g;
        commit_t e;
        int      n;
        commits_expected += exp_q.size();
        n = 0;
        while (got_q.size() < exp_q.size() && n < budget) begin
            @(negedge clock);
            n++;
        end
        // a few idle cycles catch extra commits
        repeat (3) @(negedge clock);
        if (got_q.size() != exp_q.size()) begin
            report_error($sformatf("expected %0d commits but saw %0d",
                                   exp_q.size(), got_q.size()));
        end
        // commits must arrive in program order
        while (got_q.size() > 0 && exp_q.size() > 0) begin
            g = got_q.pop_front();
            e = exp_q.pop_front();
            compare_value("commit.npc", g.npc, e.npc);
            compare_value("commit.error_status", g.error_status, e.error_status);
            compare_value("commit.wr_en", g.wr_en, e.wr_en);
            compare_value("commit.wr_idx", g.wr_idx, e.wr_idx);
            compare_value("commit.wr_data", g.wr_data, e.wr_data);
        end
        got_q.delete();
        exp_q.delete();
    endtask

    // hold > 0 keeps bready low that many cycles after bvalid
    task automatic axil_write(logic [31:0] addr, logic [31:0] data, int hold,
                              output axil_resp_e resp);
        int n;
        @(posedge clock);
        s_axil_req.awaddr  <= addr[`RETIRE_CSR_AW-1:0];
        s_axil_req.awvalid <= 1'b1;
        s_axil_req.wdata   <= data;
        s_axil_req.wstrb   <= 4'hf;
        s_axil_req.wvalid  <= 1'b1;
        s_axil_req.bready  <= (hold == 0);
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!s_axil_resp.awready && n < 16);
        if (!s_axil_resp.awready) begin
            report_error("write address and data were never accepted");
        end
        // both ready lines rise in the accepting cycle
        compare_value("wready", s_axil_resp.wready, 1'b1);
        @(posedge clock);
        s_axil_req.awvalid <= 1'b0;
        s_axil_req.wvalid  <= 1'b0;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!s_axil_resp.bvalid && n < 16);
        if (!s_axil_resp.bvalid) begin
            report_error("write response never arrived");
        end
        resp = s_axil_resp.bresp;
        repeat (hold) begin
            @(negedge clock);
            compare_value("bvalid", s_axil_resp.bvalid, 1'b1);
        end
        if (hold > 0) begin
            @(posedge clock);
            s_axil_req.bready <= 1'b1;
        end
        @(posedge clock);
        s_axil_req.bready <= 1'b0;
        @(negedge clock);
        compare_value("bvalid", s_axil_resp.bvalid, 1'b0);
    endtask

    task automatic axil_read(logic [31:0] addr, output logic [31:0] data,
                             output axil_resp_e resp);
        int n;
        @(posedge clock);
        s_axil_req.araddr  <= addr[`RETIRE_CSR_AW-1:0];
        s_axil_req.arvalid <= 1'b1;
        s_axil_req.rready  <= 1'b1;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!s_axil_resp.arready && n < 16);
        if (!s_axil_resp.arready) begin
            report_error("read address was never accepted");
        end
        @(posedge clock);
        s_axil_req.arvalid <= 1'b0;
        n = 0;
        do begin
            @(negedge clock);
            n++;
        end while (!s_axil_resp.rvalid && n < 16);
        if (!s_axil_resp.rvalid) begin
            report_error("read data never arrived");
        end
        data = s_axil_resp.rdata;
        resp = s_axil_resp.rresp;
        @(posedge clock);
        s_axil_req.rready <= 1'b0;
    endtask

    task automatic in_order_completion();
        // state straight out of reset
        compare_value("commit.valid", commit.valid, 1'b0);
        compare_value("alloc_ready", alloc_ready, 1'b1);
        compare_value("bvalid", s_axil_resp.bvalid, 1'b0);
        compare_value("rvalid", s_axil_resp.rvalid, 1'b0);
        fill_packets(tb_head, rob_sz);
        alloc_slots(rob_sz);
        for (int k = 0; k <= rob_sz; k++) begin
            @(posedge clock);
            co_packet <= (k < rob_sz) ? pk[k] : '0;
            mem2proc_response <= (k < rob_sz) ? rsp[k] : 4'h0;
            @(negedge clock);
            // previous completion shows up one cycle later
            compare_value("commit.valid", commit.valid, k > 0);
            if (k > 0) begin
                compare_value("commit.npc", commit.npc, pk[k-1].npc);
            end
        end
        compare_commits(budget_in_order);
        tb_head += rob_sz;
        // rob empty again
        compare_value("alloc_ready", alloc_ready, 1'b1);
        end_test("in-order completion");
    endtask

    task automatic out_of_order_completion();
        int j;
        int t;
        fill_packets(tb_head, rob_sz);
        // fisher-yates over completion order
        for (int k = rob_sz - 1; k > 0; k--) begin
            j = lfsr_bits(8) % (k + 1);
            t = order[k];
            order[k] = order[j];
            order[j] = t;
        end
        alloc_slots(rob_sz);
        send_completions(rob_sz);
        compare_commits(budget_out_of_order);
        tb_head += rob_sz;
        end_test("out-of-order completion");
    endtask

    task automatic exception_coding();
        logic [31:0]     rd;
        axil_resp_e      r;
        exception_code_e codes [5];
        codes = '{illegal_inst, halted_on_wfi, load_access_fault, no_error, no_error};
        fill_packets(tb_head, 5);
        exp_q.delete();
        // illegal wins over halt
        pk[0].illegal = 1'b1;
        pk[0].halt    = 1'b1;
        rsp[0]        = 4'h0;
        pk[1].halt    = 1'b1;
        // refused load
        pk[2].is_load = 1'b1;
        rsp[2]        = 4'h0;
        pk[3].is_load = 1'b1;
        rsp[3]        = 4'h3;
        // zero response on a non-load is harmless
        rsp[4]        = 4'h0;
        for (int k = 0; k < 5; k++) begin
            exp_q.push_back(expected_commit(pk[k], codes[k]));
        end
        alloc_slots(5);
        send_completions(5);
        compare_commits(budget_exceptions);
        tb_head += 5;
        // first exception sticks
        axil_read(`RETIRE_CSR_STATUS, rd, r);
        compare_value("status", rd, 32'(illegal_inst));
        axil_write(`RETIRE_CSR_STATUS, 32'h0, 0, r);
        axil_read(`RETIRE_CSR_STATUS, rd, r);
        compare_value("status", rd, 32'(no_error));
        end_test("exception status");
    endtask

    task automatic dispatch_backpressure();
        alloc_slots(rob_sz);
        @(negedge clock);
        compare_value("alloc_ready", alloc_ready, 1'b0);
        // index must hold while a request waits on a full rob
        @(posedge clock);
        alloc_valid <= 1'b1;
        repeat (2) begin
            @(negedge clock);
            compare_value("alloc_ready", alloc_ready, 1'b0);
            compare_value("alloc_index", alloc_index, tb_tail % rob_sz);
        end
        @(posedge clock);
        alloc_valid <= 1'b0;
        // retire the oldest to free one slot
        fill_packets(tb_head, 1);
        send_completions(1);
        compare_commits(budget_backpressure);
        tb_head += 1;
        alloc_slots(1);
        // drain the full rob
        fill_packets(tb_head, rob_sz);
        send_completions(rob_sz);
        compare_commits(budget_backpressure);
        tb_head += rob_sz;
        end_test("dispatch back-pressure");
    endtask

    task automatic flush_recovery();
        axil_resp_e r;
        for (int pass = 0; pass < 2; pass++) begin
            // park two entries behind an incomplete head
            fill_packets(tb_head + 1, 2);
            exp_q.delete();
            alloc_slots(4);
            send_completions(2);
            if (pass == 0) begin
                axil_write(`RETIRE_CSR_CTRL, 32'h1, 0, r);
            end else begin
                @(posedge clock);
                mispredict_flush <= 1'b1;
                @(posedge clock);
                mispredict_flush <= 1'b0;
            end
            // discarded entries must never commit
            compare_commits(8);
            tb_head = 0;
            tb_tail = 0;
            // fresh start at slot 0
            fill_packets(0, 1);
            alloc_slots(1);
            send_completions(1);
            compare_commits(budget_flush);
            tb_head = 1;
        end
        end_test("flush");
    endtask

    task automatic counter_and_handshake();
        logic [31:0] rd;
        axil_resp_e  r;
        axil_read(`RETIRE_CSR_COUNT, rd, r);
        compare_value("count", rd, commits_expected);
        compare_value("rresp", r, okay);
        fill_packets(tb_head, 3);
        alloc_slots(3);
        send_completions(3);
        compare_commits(budget_counter);
        tb_head += 3;
        axil_read(`RETIRE_CSR_COUNT, rd, r);
        compare_value("count", rd, commits_expected);
        // bvalid has to wait out a stalled bready
        axil_write(`RETIRE_CSR_STATUS, 32'h0, 4, r);
        compare_value("bresp", r, okay);
        // offset 0xc is unmapped
        axil_read(32'hc, rd, r);
        compare_value("rresp", r, slverr);
        end_test("counter and axi");
    endtask

    initial begin
        rst_n             = 1'b0;
        alloc_valid       = 1'b0;
        co_packet         = '0;
        mem2proc_response = 4'h0;
        mispredict_flush  = 1'b0;
        s_axil_req        = '0;
        tb_head           = 0;
        tb_tail           = 0;
        commits_expected  = 0;
        check_errors      = 0;
        test_errors       = 0;
        tests_passed      = 0;
        tests_failed      = 0;
        repeat (3) @(posedge clock);
        rst_n <= 1'b1;
        @(negedge clock);
        in_order_completion();
        out_of_order_completion();
        exception_coding();
        dispatch_backpressure();
        flush_recovery();
        counter_and_handshake();
        $display("%0d tests passed, %0d failed, %0d check errors",
                 tests_passed, tests_failed, check_errors);
        if (tests_failed == 0 && check_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    // watchdog at twice the summed test budgets
    initial begin
        #(watchdog_cycles * clk_period);
        $display("watchdog expired after %0d cycles, tests did not finish", watchdog_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== hw/axi_lite_pkg.sv ====
`include "retire_config.svh"

package axi_lite_pkg;

    // response codes, exokay and decerr unused
    typedef enum logic [1:0] {
        okay   = 2'b00,
        slverr = 2'b10
    } axil_resp_e;

    // master side, all five channels
    typedef struct packed {
        logic [`RETIRE_CSR_AW-1:0] awaddr;
        logic                      awvalid;
        logic [31:0]               wdata;
        logic [3:0]                wstrb;
        logic                      wvalid;
        logic                      bready;
        logic [`RETIRE_CSR_AW-1:0] araddr;
        logic                      arvalid;
        logic                      rready;
    } axil_req_t;

    // slave side
    typedef struct packed {
        logic        awready;
        logic        wready;
        axil_resp_e  bresp;
        logic        bvalid;
        logic        arready;
        logic [31:0] rdata;
        axil_resp_e  rresp;
        logic        rvalid;
    } axil_resp_t;

endpackage

// ==== hw/retire.sv ====
`timescale 1ns/1ps

`include "retire_config.svh"

module retire import retire_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,
    input  logic          flush,

    // completion, one cycle, no ready
    input  co_re_packet_t co_packet,
    input  logic [3:0]    mem2proc_response,

    // rob pointer handshake
    input  rob_idx_t      rob_head,
    output logic          move_head,

    // registered commit port
    output commit_t       commit
);

    retire_entry_t retire_buffer [`RETIRE_ROB_SZ];
    retire_entry_t incoming_entry;
    retire_entry_t outgoing_entry;
    commit_t       commit_q;
    logic          do_forward;
    logic          store_en;

    // completion aimed at the head skips the buffer
    assign do_forward = co_packet.valid && (co_packet.rob_index == rob_head);
    assign store_en   = co_packet.valid && !do_forward;

    // completion packet to retire entry
    always_comb begin
        incoming_entry.valid        = co_packet.valid;
        incoming_entry.npc          = co_packet.npc;
        incoming_entry.regfile_en   = co_packet.regfile_en;
        incoming_entry.regfile_idx  = co_packet.regfile_idx;
        incoming_entry.regfile_data = co_packet.regfile_data;
        // fixed priority: illegal, halt, failed load
        if (co_packet.illegal) begin
            incoming_entry.error_status = illegal_inst;
        end else if (co_packet.halt) begin
            incoming_entry.error_status = halted_on_wfi;
        end else if (co_packet.is_load && (mem2proc_response == 4'h0)) begin
            // zero response means the memory refused the load
            incoming_entry.error_status = load_access_fault;
        end else begin
            incoming_entry.error_status = no_error;
        end
    end

    // candidate for this cycle's commit
    always_comb begin
        if (do_forward) begin
            outgoing_entry = incoming_entry;
        end else begin
            outgoing_entry = retire_buffer[rob_head];
        end
    end

    // nothing retires while the flush pulse is up
    assign move_head = outgoing_entry.valid && !flush;

    // retire buffer
    // only the valid bits are cleared, payload stays
    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            for (int i = 0; i < `RETIRE_ROB_SZ; i++) begin
                retire_buffer[i].valid <= 1'b0;
            end
        end else begin
            // out of order completion parks in its slot
            if (store_en) begin
                retire_buffer[co_packet.rob_index] <= incoming_entry;
            end
            // head slot drained as it commits
            if (move_head && !do_forward) begin
                retire_buffer[rob_head].valid <= 1'b0;
            end
        end
    end

    // commit valid, one cycle pulse
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            commit_q.valid <= 1'b0;
        end else begin
            commit_q.valid <= move_head;
        end
    end

    // commit payload, only loaded on a retirement
    always_ff @(posedge clock) begin
        if (move_head) begin
            commit_q.error_status <= outgoing_entry.error_status;
            commit_q.wr_en        <= outgoing_entry.regfile_en;
            commit_q.wr_idx       <= outgoing_entry.regfile_idx;
            commit_q.wr_data      <= outgoing_entry.regfile_data;
            commit_q.npc          <= outgoing_entry.npc;
        end
    end

    assign commit = commit_q;

endmodule

// ==== hw/retire_config.svh ====
`ifndef RETIRE_CONFIG_SVH
`define RETIRE_CONFIG_SVH

// reorder buffer depth, power of two
`define RETIRE_ROB_SZ 8

// data and pc width
`define RETIRE_XLEN 32

// csr window address width
`define RETIRE_CSR_AW 4

// csr register offsets
// read-only retired instruction count
`define RETIRE_CSR_COUNT 4'h0
// sticky first exception code
`define RETIRE_CSR_STATUS 4'h4
// bit 0 requests a flush
`define RETIRE_CSR_CTRL 4'h8

`endif

// ==== hw/retire_csr.sv ====
`timescale 1ns/1ps

`include "retire_config.svh"

module retire_csr import retire_pkg::*, axi_lite_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,

    // axi4-lite slave
    input  axil_req_t  s_axil_req,
    output axil_resp_t s_axil_resp,

    // retired instruction stream
    input  commit_t    commit,

    // flush sources and combined pulse
    input  logic       mispredict_flush,
    output logic       flush
);

    logic            wr_fire;
    logic            wr_mapped;
    logic            rd_fire;
    logic            ctrl_flush_req;
    logic            status_clear;
    logic            status_capture;
    logic [31:0]     rd_data;
    axil_resp_e      rd_resp;

    logic            bvalid_q;
    axil_resp_e      bresp_q;
    logic            rvalid_q;
    logic [31:0]     rdata_q;
    axil_resp_e      rresp_q;
    logic [31:0]     count_q;
    exception_code_e status_q;
    logic            flush_q;

    // write needs address and data together, one response outstanding
    assign wr_fire = s_axil_req.awvalid && s_axil_req.wvalid && !bvalid_q;

    assign wr_mapped = (s_axil_req.awaddr == `RETIRE_CSR_COUNT)
                    || (s_axil_req.awaddr == `RETIRE_CSR_STATUS)
                    || (s_axil_req.awaddr == `RETIRE_CSR_CTRL);

    // ctrl bit 0, byte lane 0 must be enabled
    assign ctrl_flush_req = wr_fire && (s_axil_req.awaddr == `RETIRE_CSR_CTRL)
                         && s_axil_req.wstrb[0] && s_axil_req.wdata[0];

    // any write to status clears it
    assign status_clear = wr_fire && (s_axil_req.awaddr == `RETIRE_CSR_STATUS);

    // read accepted only with no pending response
    assign rd_fire = s_axil_req.arvalid && !rvalid_q;

    // write response channel
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            bvalid_q <= 1'b0;
        end else if (wr_fire) begin
            bvalid_q <= 1'b1;
        end else if (s_axil_req.bready) begin
            bvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (wr_fire) begin
            bresp_q <= wr_mapped ? okay : slverr;
        end
    end

    // read decode
    always_comb begin
        rd_data = '0;
        rd_resp = okay;
        case (s_axil_req.araddr)
            `RETIRE_CSR_COUNT:  rd_data = count_q;
            `RETIRE_CSR_STATUS: rd_data = 32'(status_q);
            // flush request is self clearing
            `RETIRE_CSR_CTRL:   rd_data = '0;
            default:            rd_resp = slverr;
        endcase
    end

    // read data channel
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else if (rd_fire) begin
            rvalid_q <= 1'b1;
        end else if (s_axil_req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rd_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    // retired instruction count, one per commit
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (commit.valid) begin
            count_q <= count_q + 1'b1;
        end
    end

    // first exception only, held until cleared
    assign status_capture = commit.valid && (commit.error_status != no_error)
                         && (status_q == no_error);

    always_ff @(posedge clock) begin
        if (!rst_n || status_clear) begin
            status_q <= no_error;
        end else if (status_capture) begin
            status_q <= commit.error_status;
        end
    end

    // software and mispredict flush, merged and registered
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= mispredict_flush || ctrl_flush_req;
        end
    end

    assign flush = flush_q;

    // slave response bundle
    always_comb begin
        s_axil_resp.awready = wr_fire;
        s_axil_resp.wready  = wr_fire;
        s_axil_resp.bresp   = bresp_q;
        s_axil_resp.bvalid  = bvalid_q;
        s_axil_resp.arready = !rvalid_q;
        s_axil_resp.rdata   = rdata_q;
        s_axil_resp.rresp   = rresp_q;
        s_axil_resp.rvalid  = rvalid_q;
    end

endmodule

// ==== hw/retire_pkg.sv ====
`include "retire_config.svh"

package retire_pkg;

    // rob slot number
    localparam int unsigned rob_idx_w = $clog2(`RETIRE_ROB_SZ);
    typedef logic [rob_idx_w-1:0] rob_idx_t;

    // riscv mcause style codes, plus the halt marker
    typedef enum logic [3:0] {
        illegal_inst      = 4'h2,
        load_access_fault = 4'h5,
        no_error          = 4'ha,
        halted_on_wfi     = 4'he
    } exception_code_e;

    // one completion from the execute side
    typedef struct packed {
        logic                    valid;
        rob_idx_t                rob_index;
        logic [`RETIRE_XLEN-1:0] npc;
        logic                    illegal;
        logic                    halt;
        logic                    is_load;
        logic                    regfile_en;
        logic [4:0]              regfile_idx;
        logic [`RETIRE_XLEN-1:0] regfile_data;
    } co_re_packet_t;

    // one slot of the retire buffer
    typedef struct packed {
        logic                    valid;
        logic [`RETIRE_XLEN-1:0] npc;
        exception_code_e         error_status;
        logic                    regfile_en;
        logic [4:0]              regfile_idx;
        logic [`RETIRE_XLEN-1:0] regfile_data;
    } retire_entry_t;

    // architectural commit record
    typedef struct packed {
        logic                    valid;
        exception_code_e         error_status;
        logic                    wr_en;
        logic [4:0]              wr_idx;
        logic [`RETIRE_XLEN-1:0] wr_data;
        logic [`RETIRE_XLEN-1:0] npc;
    } commit_t;

endpackage

// ==== hw/retire_unit_top.sv ====
`timescale 1ns/1ps

module retire_unit_top import retire_pkg::*, axi_lite_pkg::*; (
    input  logic          clock,
    input  logic          rst_n,

    // dispatch
    input  logic          alloc_valid,
    output logic          alloc_ready,
    output rob_idx_t      alloc_index,

    // completion
    input  co_re_packet_t co_packet,
    input  logic [3:0]    mem2proc_response,

    // branch unit
    input  logic          mispredict_flush,

    // architectural commit
    output commit_t       commit,

    // csr host port
    input  axil_req_t     s_axil_req,
    output axil_resp_t    s_axil_resp
);

    rob_idx_t rob_head;
    logic     move_head;
    logic     flush;

    // slot allocation and head tracking
    rob_pointer u_rob_pointer (
        .clock       (clock),
        .rst_n       (rst_n),
        .flush       (flush),
        .alloc_valid (alloc_valid),
        .alloc_ready (alloc_ready),
        .alloc_index (alloc_index),
        .move_head   (move_head),
        .rob_head    (rob_head)
    );

    // in order retirement
    retire u_retire (
        .clock             (clock),
        .rst_n             (rst_n),
        .flush             (flush),
        .co_packet         (co_packet),
        .mem2proc_response (mem2proc_response),
        .rob_head          (rob_head),
        .move_head         (move_head),
        .commit            (commit)
    );

    // count, status and flush control
    retire_csr u_retire_csr (
        .clock            (clock),
        .rst_n            (rst_n),
        .s_axil_req       (s_axil_req),
        .s_axil_resp      (s_axil_resp),
        .commit           (commit),
        .mispredict_flush (mispredict_flush),
        .flush            (flush)
    );

endmodule

// ==== hw/rob_pointer.sv ====
`timescale 1ns/1ps

`include "retire_config.svh"

module rob_pointer import retire_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     flush,

    // dispatch side
    input  logic     alloc_valid,
    output logic     alloc_ready,
    output rob_idx_t alloc_index,

    // retire side
    input  logic     move_head,
    output rob_idx_t rob_head
);

    // occupancy needs one bit more than an index
    localparam int unsigned cnt_w = rob_idx_w + 1;
    localparam logic [cnt_w-1:0] full_count = cnt_w'(`RETIRE_ROB_SZ);

    rob_idx_t         head_q;
    rob_idx_t         tail_q;
    logic [cnt_w-1:0] count_q;
    logic             alloc_fire;

    // full test, dispatch stalls here
    assign alloc_ready = (count_q != full_count);
    assign alloc_fire  = alloc_valid && alloc_ready;

    // next free slot is the tail
    assign alloc_index = tail_q;
    assign rob_head    = head_q;

    // tail advances per allocation, wraps with power of two size
    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            tail_q <= '0;
        end else if (alloc_fire) begin
            tail_q <= tail_q + 1'b1;
        end
    end

    // head advances per retirement
    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            head_q <= '0;
        end else if (move_head) begin
            head_q <= head_q + 1'b1;
        end
    end

    // occupancy
    // alloc and retire together cancel out
    always_ff @(posedge clock) begin
        if (!rst_n || flush) begin
            count_q <= '0;
        end else begin
            case ({alloc_fire, move_head})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule
